/* logic/core_isa_pkg.sv */
/*
  Instruction set of the multichannel integer core.
  Holds the opcode and execute operation encodings, the instruction field widths
  and the helpers that size channel indices. Modules refer to these by scoped name.
*/
package core_isa_pkg;

    localparam int OPCODE_WIDTH = 4;
    localparam int REG_FIELD_WIDTH = 4;
    localparam int INSTR_WIDTH = 16;
    // The LDR immediate takes every bit above field a
    localparam int IMM_WIDTH = INSTR_WIDTH - OPCODE_WIDTH - REG_FIELD_WIDTH;

    // Opcodes not listed here execute as NOP
    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        MUL  = 4'd3,
        LDR  = 4'd4,
        AND  = 4'd5,
        OR   = 4'd6,
        NOT  = 4'd7,
        SGT  = 4'd8,
        STOP = 4'd12
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_GT,
        ALU_IMM
    } alu_op_t;

    // A single bank still gets one index bit
    function automatic int chan_bits(input int max_channels);
        return (max_channels > 1) ? $clog2(max_channels) : 1;
    endfunction

    // A channel count runs up to max_channels itself
    function automatic int count_bits(input int max_channels);
        return $clog2(max_channels + 1);
    endfunction

endpackage

/* logic/program_fetch.sv */
/*
  Program memory and fetch sequencer.
  The host loads words through the load port, then pulses start. The program is
  issued once per channel, restarting at address 0 on every stop from the decoder.
  After the last channel busy falls and done pulses once the pipeline has drained.
*/
`timescale 1ns/10ps

module program_fetch #(
    parameter int PROG_DEPTH = 256,
    parameter int MAX_CHANNELS = 4
) (
    input  logic clock,
    input  logic rst,
    input  logic load_en,
    input  logic [$clog2(PROG_DEPTH)-1:0] load_addr,
    input  logic [core_isa_pkg::INSTR_WIDTH-1:0] load_data,
    input  logic start,
    input  logic [core_isa_pkg::count_bits(MAX_CHANNELS)-1:0] n_channels,
    output logic [core_isa_pkg::INSTR_WIDTH-1:0] instr,
    output logic [core_isa_pkg::chan_bits(MAX_CHANNELS)-1:0] instr_channel,
    output logic instr_valid,
    output logic busy,
    output logic done,
    input  logic stop
);

    localparam int PC_WIDTH = $clog2(PROG_DEPTH);
    localparam int CH_WIDTH = core_isa_pkg::chan_bits(MAX_CHANNELS);
    localparam int CNT_WIDTH = core_isa_pkg::count_bits(MAX_CHANNELS);

    logic [core_isa_pkg::INSTR_WIDTH-1:0] prog_mem [PROG_DEPTH];
    logic [PC_WIDTH-1:0] pc;
    logic [PC_WIDTH-1:0] fetch_addr;
    logic [CH_WIDTH-1:0] channel;
    logic [CH_WIDTH-1:0] next_channel;
    logic [CNT_WIDTH-1:0] n_ch_reg;
    logic [1:0] drain;
    logic last_channel;

    // A stop restarts the program in the same cycle, so address 0 is fetched directly
    assign fetch_addr = stop ? '0 : pc;
    assign next_channel = stop ? channel + 1'b1 : channel;
    assign last_channel = (CNT_WIDTH'(channel) + 1'b1) >= n_ch_reg;

    always_ff @(posedge clock) begin
        if (load_en) begin
            prog_mem[load_addr] <= load_data;
        end
        instr <= prog_mem[fetch_addr];
        instr_channel <= next_channel;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            instr_valid <= 1'b0;
            pc <= '0;
            channel <= '0;
            n_ch_reg <= '0;
            drain <= 2'd0;
        end else begin
            done <= (drain == 2'd1);
            if (drain != 2'd0) begin
                drain <= drain - 2'd1;
            end
            if (!busy) begin
                instr_valid <= 1'b0;
                // A new run waits until the previous one has signalled done
                if (start && drain == 2'd0) begin
                    busy <= 1'b1;
                    pc <= '0;
                    channel <= '0;
                    n_ch_reg <= n_channels;
                end
            end else if (stop && last_channel) begin
                busy <= 1'b0;
                instr_valid <= 1'b0;
                drain <= 2'd3;
            end else begin
                instr_valid <= 1'b1;
                pc <= fetch_addr + 1'b1;
                channel <= next_channel;
            end
        end
    end

endmodule

/* logic/instruction_decoder.sv */
/*
  Instruction decoder.
  Splits each fetched word into its fields, maps the opcode onto an execute
  operation and forms register addresses inside the bank of the word's channel.
  A STOP raises stop for one cycle and the word that follows it is dropped.
*/
`timescale 1ns/10ps

module instruction_decoder #(
    parameter int MAX_CHANNELS = 4
) (
    input  logic clock,
    input  logic rst,
    input  logic [core_isa_pkg::INSTR_WIDTH-1:0] instr,
    input  logic [core_isa_pkg::chan_bits(MAX_CHANNELS)-1:0] instr_channel,
    input  logic instr_valid,
    output logic stop,
    output logic op_valid,
    output core_isa_pkg::alu_op_t alu_op,
    output logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] addr_a,
    output logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] addr_b,
    output logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] dest_addr,
    output logic [core_isa_pkg::IMM_WIDTH-1:0] imm
);

    localparam int OPW = core_isa_pkg::OPCODE_WIDTH;
    localparam int RFW = core_isa_pkg::REG_FIELD_WIDTH;

    core_isa_pkg::opcode_t opcode;
    core_isa_pkg::alu_op_t dec_op;
    logic [RFW-1:0] field_a;
    logic [RFW-1:0] field_b;
    logic [RFW-1:0] field_d;
    logic [RFW-1:0] dec_dest;
    logic dec_valid;
    logic accept;

    assign opcode = core_isa_pkg::opcode_t'(instr[OPW-1:0]);
    assign field_a = instr[OPW+RFW-1:OPW];
    assign field_b = instr[OPW+2*RFW-1:OPW+RFW];
    assign field_d = instr[OPW+3*RFW-1:OPW+2*RFW];

    // The word fetched behind a STOP arrives while stop is high
    assign accept = instr_valid && !stop;

    always_comb begin
        dec_valid = 1'b1;
        dec_op = core_isa_pkg::ALU_ADD;
        dec_dest = field_d;
        case (opcode)
            core_isa_pkg::ADD: dec_op = core_isa_pkg::ALU_ADD;
            core_isa_pkg::SUB: dec_op = core_isa_pkg::ALU_SUB;
            core_isa_pkg::MUL: dec_op = core_isa_pkg::ALU_MUL;
            core_isa_pkg::AND: dec_op = core_isa_pkg::ALU_AND;
            core_isa_pkg::OR:  dec_op = core_isa_pkg::ALU_OR;
            core_isa_pkg::SGT: dec_op = core_isa_pkg::ALU_GT;
            core_isa_pkg::NOT: begin
                dec_op = core_isa_pkg::ALU_NOT;
                dec_dest = field_b;
            end
            core_isa_pkg::LDR: begin
                dec_op = core_isa_pkg::ALU_IMM;
                dec_dest = field_a;
            end
            // NOP, STOP and unused codes issue nothing
            default: dec_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            stop <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            stop <= accept && (opcode == core_isa_pkg::STOP);
            op_valid <= accept && dec_valid;
        end
    end

    // Bank select is the channel in the upper address bits
    always_ff @(posedge clock) begin
        alu_op <= dec_op;
        addr_a <= {instr_channel, field_a};
        addr_b <= {instr_channel, field_b};
        dest_addr <= {instr_channel, dec_dest};
        imm <= instr[core_isa_pkg::INSTR_WIDTH-1:OPW+RFW];
    end

endmodule

/* logic/register_file.sv */
/*
  Banked register file, sixteen registers per channel.
  Reads both operands for the decoded instruction in one registered cycle and
  forwards its control to execute. Takes the write-back and serves host readback.
*/
`timescale 1ns/10ps

module register_file #(
    parameter int DATA_WIDTH = 16,
    parameter int MAX_CHANNELS = 4
) (
    input  logic clock,
    input  logic rst,
    input  logic op_valid,
    input  core_isa_pkg::alu_op_t alu_op,
    input  logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] addr_a,
    input  logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] addr_b,
    input  logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] dest_addr,
    input  logic [core_isa_pkg::IMM_WIDTH-1:0] imm,
    input  logic wr_en,
    input  logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] read_addr,
    output logic exe_valid,
    output core_isa_pkg::alu_op_t exe_op,
    output logic [DATA_WIDTH-1:0] operand_a,
    output logic [DATA_WIDTH-1:0] operand_b,
    output logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] exe_dest,
    output logic [core_isa_pkg::IMM_WIDTH-1:0] exe_imm,
    output logic [DATA_WIDTH-1:0] read_data
);

    localparam int NUM_REGS = 2 ** (core_isa_pkg::chan_bits(MAX_CHANNELS) +
                                    core_isa_pkg::REG_FIELD_WIDTH);

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= op_valid;
        end
    end

    always_ff @(posedge clock) begin
        operand_a <= regs[addr_a];
        operand_b <= regs[addr_b];
        exe_op <= alu_op;
        exe_dest <= dest_addr;
        exe_imm <= imm;
    end

    // Host readback is only meaningful once the core is idle
    assign read_data = regs[read_addr];

endmodule

/* logic/alu_stage.sv */
/*
  Execute stage.
  Computes one result per cycle from the forwarded operands and drives the
  write-back into the register file one cycle later.
*/
`timescale 1ns/10ps

module alu_stage #(
    parameter int DATA_WIDTH = 16,
    parameter int MAX_CHANNELS = 4
) (
    input  logic clock,
    input  logic rst,
    input  logic exe_valid,
    input  core_isa_pkg::alu_op_t exe_op,
    input  logic [DATA_WIDTH-1:0] operand_a,
    input  logic [DATA_WIDTH-1:0] operand_b,
    input  logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] exe_dest,
    input  logic [core_isa_pkg::IMM_WIDTH-1:0] exe_imm,
    output logic wr_en,
    output logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] wr_addr,
    output logic [DATA_WIDTH-1:0] wr_data
);

    logic [DATA_WIDTH-1:0] result;

    // Arithmetic wraps and keeps only the low DATA_WIDTH bits
    always_comb begin
        case (exe_op)
            core_isa_pkg::ALU_ADD: result = operand_a + operand_b;
            core_isa_pkg::ALU_SUB: result = operand_a - operand_b;
            core_isa_pkg::ALU_MUL: result = operand_a * operand_b;
            core_isa_pkg::ALU_AND: result = operand_a & operand_b;
            core_isa_pkg::ALU_OR:  result = operand_a | operand_b;
            core_isa_pkg::ALU_NOT: result = ~operand_a;
            // Unsigned compare
            core_isa_pkg::ALU_GT:  result = DATA_WIDTH'(operand_a > operand_b);
            core_isa_pkg::ALU_IMM: result = DATA_WIDTH'(exe_imm);
            default:               result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= exe_valid;
        end
    end

    always_ff @(posedge clock) begin
        wr_addr <= exe_dest;
        wr_data <= result;
    end

endmodule

/* logic/dsp_core_top.sv */
/*
  Top level of the multichannel integer core.
  Chains fetch, decode, operand read and execute, and sets the data width,
  program depth and channel count for every stage.
*/
`timescale 1ns/10ps

module dsp_core_top #(
    parameter int DATA_WIDTH = 16,
    parameter int PROG_DEPTH = 256,
    parameter int MAX_CHANNELS = 4
) (
    input  logic clock,
    input  logic rst,
    input  logic load_en,
    input  logic [$clog2(PROG_DEPTH)-1:0] load_addr,
    input  logic [core_isa_pkg::INSTR_WIDTH-1:0] load_data,
    input  logic start,
    input  logic [core_isa_pkg::count_bits(MAX_CHANNELS)-1:0] n_channels,
    input  logic [core_isa_pkg::chan_bits(MAX_CHANNELS)+core_isa_pkg::REG_FIELD_WIDTH-1:0] read_addr,
    output logic busy,
    output logic done,
    output logic [DATA_WIDTH-1:0] read_data
);

    localparam int CH_WIDTH = core_isa_pkg::chan_bits(MAX_CHANNELS);
    localparam int ADDR_WIDTH = CH_WIDTH + core_isa_pkg::REG_FIELD_WIDTH;

    logic [core_isa_pkg::INSTR_WIDTH-1:0] instr;
    logic [CH_WIDTH-1:0] instr_channel;
    logic instr_valid;
    logic stop;
    logic op_valid;
    core_isa_pkg::alu_op_t alu_op;
    logic [ADDR_WIDTH-1:0] addr_a;
    logic [ADDR_WIDTH-1:0] addr_b;
    logic [ADDR_WIDTH-1:0] dest_addr;
    logic [core_isa_pkg::IMM_WIDTH-1:0] imm;
    logic exe_valid;
    core_isa_pkg::alu_op_t exe_op;
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] operand_b;
    logic [ADDR_WIDTH-1:0] exe_dest;
    logic [core_isa_pkg::IMM_WIDTH-1:0] exe_imm;
    logic wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] wr_data;

    program_fetch #(.PROG_DEPTH(PROG_DEPTH), .MAX_CHANNELS(MAX_CHANNELS)) u_program_fetch (
        .clock(clock), .rst(rst), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .start(start), .n_channels(n_channels),
        .instr(instr), .instr_channel(instr_channel), .instr_valid(instr_valid),
        .busy(busy), .done(done), .stop(stop)
    );

    instruction_decoder #(.MAX_CHANNELS(MAX_CHANNELS)) u_instruction_decoder (
        .clock(clock), .rst(rst), .instr(instr), .instr_channel(instr_channel),
        .instr_valid(instr_valid), .stop(stop), .op_valid(op_valid), .alu_op(alu_op),
        .addr_a(addr_a), .addr_b(addr_b), .dest_addr(dest_addr), .imm(imm)
    );

    register_file #(.DATA_WIDTH(DATA_WIDTH), .MAX_CHANNELS(MAX_CHANNELS)) u_register_file (
        .clock(clock), .rst(rst), .op_valid(op_valid), .alu_op(alu_op),
        .addr_a(addr_a), .addr_b(addr_b), .dest_addr(dest_addr), .imm(imm),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .read_addr(read_addr),
        .exe_valid(exe_valid), .exe_op(exe_op), .operand_a(operand_a),
        .operand_b(operand_b), .exe_dest(exe_dest), .exe_imm(exe_imm),
        .read_data(read_data)
    );

    alu_stage #(.DATA_WIDTH(DATA_WIDTH), .MAX_CHANNELS(MAX_CHANNELS)) u_alu_stage (
        .clock(clock), .rst(rst), .exe_valid(exe_valid), .exe_op(exe_op),
        .operand_a(operand_a), .operand_b(operand_b), .exe_dest(exe_dest),
        .exe_imm(exe_imm), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

endmodule

/* tests/core_asserts.sv */
/*
  Protocol checks for the multichannel core, bound onto dsp_core_top.
  Watches the run handshake and the write-back strobe of the execute stage.
*/
`timescale 1ns/10ps

module core_asserts (
    input logic clock,
    input logic rst,
    input logic busy,
    input logic done,
    input logic wr_en
);

    int assert_errors = 0;

    done_while_idle: assert property (@(posedge clock) disable iff (rst) !(done && busy))
        else begin
            $error("done is high while the core is busy");
            assert_errors++;
        end

    done_single_cycle: assert property (@(posedge clock) disable iff (rst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            assert_errors++;
        end

    // A write may still land during the three drain cycles after busy falls
    write_after_drain: assert property (@(posedge clock) disable iff (rst)
        $rose(wr_en) |-> ($past(busy, 1) || $past(busy, 2) || $past(busy, 3)))
        else begin
            $error("write-back started after the pipeline had drained");
            assert_errors++;
        end

endmodule

bind dsp_core_top core_asserts u_core_asserts (
    .clock(clock),
    .rst(rst),
    .busy(busy),
    .done(done),
    .wr_en(wr_en)
);

/* tests/core_tb.sv */
/*
  Directed testbench for the multichannel integer core.
  Loads small programs, runs them over one or more channels and compares every
  register against a reference model of the instruction set.
*/
`timescale 1ns/10ps

module core_tb;

    logic clock = 1'b0;
    logic rst;
    logic load_en;
    logic [7:0] load_addr;
    logic [15:0] load_data;
    logic start;
    logic [2:0] n_channels;
    logic [5:0] read_addr;
    logic busy;
    logic done;
    logic [15:0] read_data;

    logic [15:0] prog [$];
    logic [15:0] model_regs [64];
    int error_count = 0;
    int check_count = 0;
    int total_errors;
    int seed_value;

    dsp_core_top #(.DATA_WIDTH(16), .PROG_DEPTH(256), .MAX_CHANNELS(4)) u_dsp_core_top (
        .clock(clock), .rst(rst), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .start(start), .n_channels(n_channels),
        .read_addr(read_addr), .busy(busy), .done(done), .read_data(read_data)
    );

    always #50 clock = ~clock;

    function automatic logic [15:0] reg_op_word(input logic [3:0] op, input logic [3:0] d,
                                                input logic [3:0] b, input logic [3:0] a);
        return {d, b, a, op};
    endfunction

    function automatic logic [15:0] ldr(input logic [3:0] d, input logic [7:0] value);
        return {value, d, 4'(core_isa_pkg::LDR)};
    endfunction

    // Every instruction is followed by three NOPs to respect the hazard rule
    function automatic void emit(input logic [15:0] word);
        prog.push_back(word);
        repeat (3) prog.push_back(16'h0000);
    endfunction

    // Reference model of one instruction that returns 1 on STOP
    function automatic bit model_step(input logic [15:0] word, input int ch);
        logic [15:0] a;
        logic [15:0] b;
        int base;
        base = ch * 16;
        a = model_regs[base + int'(word[7:4])];
        b = model_regs[base + int'(word[11:8])];
        case (word[3:0])
            core_isa_pkg::ADD: model_regs[base + int'(word[15:12])] = a + b;
            core_isa_pkg::SUB: model_regs[base + int'(word[15:12])] = a - b;
            core_isa_pkg::MUL: model_regs[base + int'(word[15:12])] = a * b;
            core_isa_pkg::AND: model_regs[base + int'(word[15:12])] = a & b;
            core_isa_pkg::OR:  model_regs[base + int'(word[15:12])] = a | b;
            core_isa_pkg::NOT: model_regs[base + int'(word[11:8])] = ~a;
            core_isa_pkg::SGT: model_regs[base + int'(word[15:12])] = (a > b) ? 16'd1 : 16'd0;
            core_isa_pkg::LDR: model_regs[base + int'(word[7:4])] = {8'h00, word[15:8]};
            core_isa_pkg::STOP: return 1'b1;
            default: ;
        endcase
        return 1'b0;
    endfunction

    task automatic model_run(input int n_ch);
        int pc;
        bit stopped;
        for (int ch = 0; ch < n_ch; ch++) begin
            pc = 0;
            stopped = 1'b0;
            while (!stopped && pc < prog.size()) begin
                stopped = model_step(prog[pc], ch);
                pc++;
            end
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clock);
            load_en = 1'b1;
            load_addr = 8'(i);
            load_data = prog[i];
        end
        @(negedge clock);
        load_en = 1'b0;
    endtask

    task automatic run_program(input int n_ch, input int second_start_after);
        int cycles;
        @(negedge clock);
        n_channels = 3'(n_ch);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        if (second_start_after > 0) begin
            repeat (second_start_after) @(negedge clock);
            assert (busy) else begin
                $display("core was not busy when the second start pulse was given");
                error_count++;
            end
            start = 1'b1;
            @(negedge clock);
            start = 1'b0;
        end
        cycles = 0;
        while (!done && cycles < 5000) begin
            @(negedge clock);
            cycles++;
        end
        assert (done) else begin
            $display("timed out waiting for done after %0d cycles", cycles);
            error_count++;
        end
        model_run(n_ch);
    endtask

    task automatic check_reg(input int addr, input logic [15:0] expected);
        @(negedge clock);
        read_addr = 6'(addr);
        #1;
        check_count++;
        assert (read_data === expected) else begin
            $display("mismatch at %0t: register %0d reads %h, expected %h",
                     $time, addr, read_data, expected);
            error_count++;
        end
    endtask

    task automatic check_all();
        for (int i = 0; i < 64; i++) begin
            check_reg(i, model_regs[i]);
        end
    endtask

    task automatic after_reset();
        assert (!busy && !done) else begin
            $display("mismatch at %0t: busy=%b done=%b after reset", $time, busy, done);
            error_count++;
        end
        check_all();
    endtask

    task automatic arith_ops();
        prog.delete();
        emit(ldr(4'd1, 8'hff));
        emit(ldr(4'd2, 8'h03));
        emit(ldr(4'd3, 8'hc8));
        emit(reg_op_word(core_isa_pkg::ADD, 4'd4, 4'd2, 4'd1));
        emit(reg_op_word(core_isa_pkg::SUB, 4'd5, 4'd1, 4'd2));
        emit(reg_op_word(core_isa_pkg::MUL, 4'd6, 4'd1, 4'd1));
        // Both of these overflow 16 bits
        emit(reg_op_word(core_isa_pkg::MUL, 4'd7, 4'd3, 4'd6));
        emit(reg_op_word(core_isa_pkg::ADD, 4'd8, 4'd6, 4'd6));
        prog.push_back(reg_op_word(core_isa_pkg::STOP, 4'd0, 4'd0, 4'd0));
        load_program();
        run_program(1, 0);
        check_all();
    endtask

    task automatic logic_ops();
        prog.delete();
        emit(ldr(4'd8, 8'ha5));
        emit(ldr(4'd9, 8'h3c));
        emit(ldr(4'd10, 8'ha5));
        emit(reg_op_word(core_isa_pkg::AND, 4'd11, 4'd9, 4'd8));
        emit(reg_op_word(core_isa_pkg::OR, 4'd12, 4'd9, 4'd8));
        emit(reg_op_word(core_isa_pkg::NOT, 4'd0, 4'd13, 4'd8));
        emit(reg_op_word(core_isa_pkg::SGT, 4'd14, 4'd10, 4'd8));
        emit(reg_op_word(core_isa_pkg::SGT, 4'd15, 4'd9, 4'd8));
        // r13 has its top bit set, so a signed compare would give 1 here
        emit(reg_op_word(core_isa_pkg::SGT, 4'd0, 4'd13, 4'd9));
        prog.push_back(reg_op_word(core_isa_pkg::STOP, 4'd0, 4'd0, 4'd0));
        load_program();
        run_program(1, 0);
        check_all();
    endtask

    task automatic channel_banks();
        prog.delete();
        emit(ldr(4'd1, 8'h12));
        emit(ldr(4'd2, 8'h34));
        emit(reg_op_word(core_isa_pkg::ADD, 4'd3, 4'd2, 4'd1));
        prog.push_back(reg_op_word(core_isa_pkg::STOP, 4'd0, 4'd0, 4'd0));
        load_program();
        run_program(3, 0);
        check_all();
    endtask

    // The ADD accumulates, so a restarted run would leave a different r3
    task automatic stop_squash();
        prog.delete();
        emit(ldr(4'd1, 8'h05));
        emit(reg_op_word(core_isa_pkg::ADD, 4'd3, 4'd1, 4'd3));
        // Keeps the core busy well past the second start pulse
        repeat (8) prog.push_back(16'h0000);
        prog.push_back(reg_op_word(core_isa_pkg::STOP, 4'd0, 4'd0, 4'd0));
        prog.push_back(ldr(4'd15, 8'hab));
        load_program();
        run_program(1, 8);
        check_all();
    endtask

    task automatic random_programs();
        for (int run = 0; run < 20; run++) begin
            prog.delete();
            for (int i = 0; i < 4; i++) begin
                emit(ldr(4'($urandom % 16), 8'($urandom % 256)));
            end
            // Opcodes 9 to 11 are unused and must act as NOP
            for (int i = 0; i < 8; i++) begin
                emit(reg_op_word(4'($urandom % 12), 4'($urandom % 16), 4'($urandom % 16),
                                 4'($urandom % 16)));
            end
            prog.push_back(reg_op_word(core_isa_pkg::STOP, 4'd0, 4'd0, 4'd0));
            load_program();
            run_program(1 + int'($urandom % 4), 0);
            check_all();
        end
    endtask

    initial begin
        rst = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        start = 1'b0;
        n_channels = 3'd1;
        read_addr = '0;
        seed_value = $urandom(32'h80d4);
        for (int i = 0; i < 64; i++) begin
            model_regs[i] = 16'h0000;
        end
        repeat (8) @(negedge clock);
        rst = 1'b0;

        after_reset();
        arith_ops();
        logic_ops();
        channel_banks();
        stop_squash();
        random_programs();

        total_errors = error_count + u_dsp_core_top.u_core_asserts.assert_errors;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, u_dsp_core_top.u_core_asserts.assert_errors);
        if (total_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sources.f */
logic/core_isa_pkg.sv
logic/program_fetch.sv
logic/instruction_decoder.sv
logic/register_file.sv
logic/alu_stage.sv
logic/dsp_core_top.sv
tests/core_asserts.sv
tests/core_tb.sv
